/* rtl/glb_pkg.sv */
package glb_pkg;

    // chain geometry
    localparam int NUM_TILES = 4;

    // bank word, also the host data width
    localparam int BANK_DATA_WIDTH = 64;
    localparam int BANK_STRB_WIDTH = BANK_DATA_WIDTH / 8;

    // words per bank
    localparam int BANK_ADDR_WIDTH = 8;
    localparam int BANK_DEPTH = 1 << BANK_ADDR_WIDTH;

    // byte offset bits below the word index, not decoded
    localparam int BYTE_OFFSET_WIDTH = $clog2(BANK_STRB_WIDTH);

    // tile select sits in the top bits of the host address
    localparam int TILE_SEL_WIDTH = $clog2(NUM_TILES);

    // host byte address: tile select, word index, byte offset
    localparam int GLB_ADDR_WIDTH = TILE_SEL_WIDTH + BANK_ADDR_WIDTH + BYTE_OFFSET_WIDTH;

endpackage

/* rtl/glb_req_if.sv */
`timescale 1ns/100ps

interface glb_req_if import glb_pkg::*; ();

    logic                         req_valid;
    logic                         req_we;
    logic [BANK_STRB_WIDTH-1:0]   req_strb;
    logic [GLB_ADDR_WIDTH-1:0]    req_addr;
    logic [BANK_DATA_WIDTH-1:0]   req_wdata;

    // east side, the bridge or the previous tile
    modport src (
        output req_valid,
        output req_we,
        output req_strb,
        output req_addr,
        output req_wdata
    );

    // west side, the next tile
    modport dst (
        input  req_valid,
        input  req_we,
        input  req_strb,
        input  req_addr,
        input  req_wdata
    );

endinterface

/* rtl/glb_bank.sv */
`timescale 1ns/100ps

module glb_bank import glb_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         stall,

    input  logic                         wr_en,
    input  logic                         rd_en,
    input  logic [BANK_ADDR_WIDTH-1:0]   addr,
    input  logic [BANK_STRB_WIDTH-1:0]   strb,
    input  logic [BANK_DATA_WIDTH-1:0]   wdata,

    output logic [BANK_DATA_WIDTH-1:0]   rdata,
    output logic                         rdata_valid
);

    logic [BANK_DATA_WIDTH-1:0] mem [BANK_DEPTH];

    logic do_write;
    logic do_read;

    // nothing moves while the chain is frozen
    assign do_write = wr_en && !stall;
    assign do_read  = rd_en && !stall;

    // byte merge, unstrobed lanes keep old contents
    always_ff @(posedge clk) begin
        if (do_write) begin
            for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
                if (strb[b]) begin
                    mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // one-cycle read
    always_ff @(posedge clk) begin
        if (do_read) begin
            rdata <= mem[addr];
        end
    end

    // single pulse per read, frozen along with rdata
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_valid <= 1'b0;
        end else if (!stall) begin
            rdata_valid <= rd_en;
        end
    end

endmodule

/* rtl/glb_tile.sv */
`timescale 1ns/100ps

module glb_tile import glb_pkg::*; #(
    parameter int TILE_ID = 0
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         stall,

    // requests travel west
    glb_req_if.dst                       req_in,
    glb_req_if.src                       req_out,

    // responses travel east
    input  logic                         rsp_in_valid,
    input  logic [BANK_DATA_WIDTH-1:0]   rsp_in_data,
    output logic                         rsp_out_valid,
    output logic [BANK_DATA_WIDTH-1:0]   rsp_out_data
);

    logic [TILE_SEL_WIDTH-1:0]   tile_sel;
    logic [BANK_ADDR_WIDTH-1:0]  word_idx;
    logic                        tile_hit;
    logic                        bank_wr_en;
    logic                        bank_rd_en;

    logic [BANK_DATA_WIDTH-1:0]  bank_rdata;
    logic                        bank_rdata_valid;

    logic                        rsp_hop_valid;
    logic [BANK_DATA_WIDTH-1:0]  rsp_hop_data;

    // address decode
    assign tile_sel = req_in.req_addr[GLB_ADDR_WIDTH-1 -: TILE_SEL_WIDTH];
    assign word_idx = req_in.req_addr[BYTE_OFFSET_WIDTH +: BANK_ADDR_WIDTH];
    assign tile_hit = req_in.req_valid && (tile_sel == TILE_SEL_WIDTH'(TILE_ID));

    assign bank_wr_en = tile_hit && req_in.req_we;
    assign bank_rd_en = tile_hit && !req_in.req_we;

    glb_bank u_bank (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .wr_en       (bank_wr_en),
        .rd_en       (bank_rd_en),
        .addr        (word_idx),
        .strb        (req_in.req_strb),
        .wdata       (req_in.req_wdata),
        .rdata       (bank_rdata),
        .rdata_valid (bank_rdata_valid)
    );

    // westward hop, every request is forwarded whether it hit here or not
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_out.req_valid <= 1'b0;
        end else if (!stall) begin
            req_out.req_valid <= req_in.req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && req_in.req_valid) begin
            req_out.req_we    <= req_in.req_we;
            req_out.req_strb  <= req_in.req_strb;
            req_out.req_addr  <= req_in.req_addr;
            req_out.req_wdata <= req_in.req_wdata;
        end
    end

    // eastward hop for responses from tiles further west
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_hop_valid <= 1'b0;
        end else if (!stall) begin
            rsp_hop_valid <= rsp_in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && rsp_in_valid) begin
            rsp_hop_data <= rsp_in_data;
        end
    end

    // bank output is already registered, so it joins after the hop
    // only one read is in flight, the two sources never overlap
    assign rsp_out_valid = bank_rdata_valid || rsp_hop_valid;
    assign rsp_out_data  = bank_rdata_valid ? bank_rdata : rsp_hop_data;

endmodule

/* rtl/glb_host_bridge.sv */
`timescale 1ns/100ps

module glb_host_bridge import glb_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         stall,

    // wishbone classic slave
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [GLB_ADDR_WIDTH-1:0]    wb_adr,
    input  logic [BANK_STRB_WIDTH-1:0]   wb_sel,
    input  logic [BANK_DATA_WIDTH-1:0]   wb_wdata,
    output logic                         wb_ack,
    output logic [BANK_DATA_WIDTH-1:0]   wb_rdata,

    // east end of the tile chain
    glb_req_if.src                       req,
    input  logic                         rsp_valid,
    input  logic [BANK_DATA_WIDTH-1:0]   rsp_data
);

    logic launch;
    logic rd_pending;
    logic rd_done;

    // new transfer: the ack cycle of the previous one is skipped,
    // since the master still holds stb while it sees ack
    assign launch  = wb_cyc && wb_stb && !wb_ack && !rd_pending;
    assign rd_done = rd_pending && rsp_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req.req_valid <= 1'b0;
            rd_pending    <= 1'b0;
            wb_ack        <= 1'b0;
        end else if (!stall) begin
            req.req_valid <= launch;
            // writes ack on launch, reads when the data gets back
            wb_ack <= (launch && wb_we) || rd_done;
            if (launch && !wb_we) begin
                rd_pending <= 1'b1;
            end else if (rd_done) begin
                rd_pending <= 1'b0;
            end
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (!stall && launch) begin
            req.req_we    <= wb_we;
            req.req_strb  <= wb_sel;
            req.req_addr  <= wb_adr;
            req.req_wdata <= wb_wdata;
        end
    end

    // read data lines up with ack
    always_ff @(posedge clk) begin
        if (!stall && rd_done) begin
            wb_rdata <= rsp_data;
        end
    end

endmodule

/* rtl/global_buffer.sv */
`timescale 1ns/100ps

module global_buffer import glb_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         stall,

    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [GLB_ADDR_WIDTH-1:0]    wb_adr,
    input  logic [BANK_STRB_WIDTH-1:0]   wb_sel,
    input  logic [BANK_DATA_WIDTH-1:0]   wb_wdata,
    output logic [BANK_DATA_WIDTH-1:0]   wb_rdata,
    output logic                         wb_ack
);

    // req_link[k+1] feeds tile k, req_link[0] is the dead end west of tile 0
    glb_req_if req_link [NUM_TILES+1] ();

    // rsp_*_link[k] enters tile k from the west, index NUM_TILES goes to the bridge
    logic [NUM_TILES:0]          rsp_valid_link;
    logic [BANK_DATA_WIDTH-1:0]  rsp_data_link [NUM_TILES+1];

    // nothing west of tile 0
    assign rsp_valid_link[0] = 1'b0;
    assign rsp_data_link[0]  = '0;

    glb_host_bridge u_host_bridge (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_sel    (wb_sel),
        .wb_wdata  (wb_wdata),
        .wb_ack    (wb_ack),
        .wb_rdata  (wb_rdata),
        .req       (req_link[NUM_TILES]),
        .rsp_valid (rsp_valid_link[NUM_TILES]),
        .rsp_data  (rsp_data_link[NUM_TILES])
    );

    genvar k;
    generate
        for (k = 0; k < NUM_TILES; k++) begin : g_tile
            glb_tile #(
                .TILE_ID (k)
            ) u_tile (
                .clk           (clk),
                .rst_n         (rst_n),
                .stall         (stall),
                .req_in        (req_link[k+1]),
                .req_out       (req_link[k]),
                .rsp_in_valid  (rsp_valid_link[k]),
                .rsp_in_data   (rsp_data_link[k]),
                .rsp_out_valid (rsp_valid_link[k+1]),
                .rsp_out_data  (rsp_data_link[k+1])
            );
        end
    endgenerate

endmodule

/* tests/global_buffer_assertions.sv */
`timescale 1ns/100ps

module global_buffer_assertions import glb_pkg::*; (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         stall,
    input logic                         wb_cyc,
    input logic                         wb_stb,
    input logic                         wb_we,
    input logic [GLB_ADDR_WIDTH-1:0]    wb_adr,
    input logic [BANK_STRB_WIDTH-1:0]   wb_sel,
    input logic [BANK_DATA_WIDTH-1:0]   wb_wdata,
    input logic [BANK_DATA_WIDTH-1:0]   wb_rdata,
    input logic                         wb_ack
);

    int fail_count = 0;

    logic [BANK_DATA_WIDTH-1:0]                 shadow [NUM_TILES*BANK_DEPTH];
    logic [TILE_SEL_WIDTH+BANK_ADDR_WIDTH-1:0]  word_addr;
    logic [TILE_SEL_WIDTH-1:0]                  tile;
    logic                                       busy;
    logic [7:0]                                 cnt;
    logic [7:0]                                 exp_lat;

    assign word_addr = wb_adr[GLB_ADDR_WIDTH-1:BYTE_OFFSET_WIDTH];
    assign tile      = wb_adr[GLB_ADDR_WIDTH-1 -: TILE_SEL_WIDTH];

    // shadow follows acknowledged writes, byte by byte
    always_ff @(posedge clk) begin
        if (rst_n && wb_ack && wb_we) begin
            for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
                if (wb_sel[b]) begin
                    shadow[word_addr][b*8 +: 8] <= wb_wdata[b*8 +: 8];
                end
            end
        end
    end

    // counts unstalled edges since the transfer was taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            cnt     <= '0;
            exp_lat <= '0;
        end else if (!stall) begin
            if (!busy && wb_cyc && wb_stb && !wb_ack) begin
                busy    <= 1'b1;
                cnt     <= 8'd1;
                exp_lat <= wb_we ? 8'd1 : 8'(2 * (NUM_TILES - 1 - int'(tile)) + 3);
            end else if (busy) begin
                cnt <= cnt + 8'd1;
                if (wb_ack) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    reset_ack_low: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> !wb_ack)
    else begin
        fail_count++;
        $error("ERROR at %0t: wb_ack high during or right after reset", $time);
    end

    ack_inside_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> wb_cyc && wb_stb)
    else begin
        fail_count++;
        $error("ERROR at %0t: wb_ack high without cyc and stb", $time);
    end

    ack_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack && $past(wb_ack) |-> $past(stall))
    else begin
        fail_count++;
        $error("ERROR at %0t: wb_ack high on two cycles without stall", $time);
    end

    no_ack_rise_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall && !wb_ack |=> !wb_ack)
    else begin
        fail_count++;
        $error("ERROR at %0t: wb_ack rose while stall was high", $time);
    end

    ack_latency: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> busy && cnt == exp_lat)
    else begin
        fail_count++;
        $error("ERROR at %0t: ack after %0d cycles, expected %0d", $time,
               $sampled(cnt), $sampled(exp_lat));
    end

    ack_not_late: assert property (@(posedge clk) disable iff (!rst_n)
        busy && !wb_ack |-> cnt < exp_lat)
    else begin
        fail_count++;
        $error("ERROR at %0t: no ack after %0d cycles", $time, $sampled(cnt));
    end

    read_data_match: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack && !wb_we |-> wb_rdata == shadow[word_addr])
    else begin
        fail_count++;
        $error("ERROR at %0t: read of word %h returned %h, expected %h", $time,
               $sampled(word_addr), $sampled(wb_rdata), shadow[$sampled(word_addr)]);
    end

endmodule

bind global_buffer global_buffer_assertions u_global_buffer_assertions (.*);

/* tests/glb_host_tasks.svh */
`ifndef GLB_HOST_TASKS_SVH
`define GLB_HOST_TASKS_SVH

// every task starts and ends on a falling edge

task automatic drive_bus(
    input logic                         we,
    input logic [GLB_ADDR_WIDTH-1:0]    addr,
    input logic [BANK_STRB_WIDTH-1:0]   sel,
    input logic [BANK_DATA_WIDTH-1:0]   data
);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = addr;
    wb_sel   = sel;
    wb_wdata = data;
endtask

task automatic release_bus();
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
endtask

// ack is registered, so the bus stays up through the edge that samples it
task automatic wait_for_ack();
    do begin
        @(negedge clk);
    end while (wb_ack !== 1'b1);
    @(negedge clk);
endtask

task automatic write_word(
    input logic [GLB_ADDR_WIDTH-1:0]    addr,
    input logic [BANK_STRB_WIDTH-1:0]   sel,
    input logic [BANK_DATA_WIDTH-1:0]   data
);
    drive_bus(1'b1, addr, sel, data);
    wait_for_ack();
    release_bus();
endtask

task automatic read_word(input logic [GLB_ADDR_WIDTH-1:0] addr);
    drive_bus(1'b0, addr, '0, '0);
    wait_for_ack();
    release_bus();
endtask

// stall rises delay cycles after the strobe and lasts len cycles
task automatic access_with_stall(
    input logic                         we,
    input logic [GLB_ADDR_WIDTH-1:0]    addr,
    input logic [BANK_STRB_WIDTH-1:0]   sel,
    input logic [BANK_DATA_WIDTH-1:0]   data,
    input int                           delay,
    input int                           len
);
    drive_bus(we, addr, sel, data);
    repeat (delay) @(negedge clk);
    stall = 1'b1;
    repeat (len) @(negedge clk);
    stall = 1'b0;
    wait_for_ack();
    release_bus();
endtask

task automatic idle_stall(input int len);
    stall = 1'b1;
    repeat (len) @(negedge clk);
    stall = 1'b0;
endtask

`endif

/* tests/tb_global_buffer.sv */
`timescale 1ns/100ps

module tb_global_buffer import glb_pkg::*; ();

    // about 150 transfers of at most 10 cycles, plus stall windows
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int WORDS_PER_TILE = 8;

    logic                         clk;
    logic                         rst_n;
    logic                         stall;
    logic                         wb_cyc;
    logic                         wb_stb;
    logic                         wb_we;
    logic [GLB_ADDR_WIDTH-1:0]    wb_adr;
    logic [BANK_STRB_WIDTH-1:0]   wb_sel;
    logic [BANK_DATA_WIDTH-1:0]   wb_wdata;
    logic [BANK_DATA_WIDTH-1:0]   wb_rdata;
    logic                         wb_ack;

    integer seed = 32'h1cdf;
    int cycle_count = 0;

    // every address here got a full write first
    logic [GLB_ADDR_WIDTH-1:0] written [$];

    global_buffer u_global_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_sel   (wb_sel),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack)
    );

    `include "glb_host_tasks.svh"

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [GLB_ADDR_WIDTH-1:0] make_addr(input int tile, input int idx);
        return {TILE_SEL_WIDTH'(tile), BANK_ADDR_WIDTH'(idx), BYTE_OFFSET_WIDTH'(0)};
    endfunction

    function automatic logic [BANK_DATA_WIDTH-1:0] random_word();
        return {$random(seed), $random(seed)};
    endfunction

    always @(negedge clk) begin
        if (u_global_buffer.u_global_buffer_assertions.fail_count != 0) begin
            $display("ERROR at %0t: a check in global_buffer_assertions failed", $time);
            $display("Simulation FAILED");
            $fatal(1, "run stopped at the first error");
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [BANK_STRB_WIDTH-1:0] sel;
        int pick;

        rst_n    = 1'b0;
        stall    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_sel   = '0;
        wb_wdata = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);

        // same word index in every tile, no aliasing on tile select
        for (int t = 0; t < NUM_TILES; t++) begin
            write_word(make_addr(t, 8'h5a), '1, random_word());
        end
        for (int t = 0; t < NUM_TILES; t++) begin
            read_word(make_addr(t, 8'h5a));
        end

        for (int t = 0; t < NUM_TILES; t++) begin
            for (int i = 0; i < WORDS_PER_TILE; i++) begin
                written.push_back(make_addr(t, (i * 37 + 3) % BANK_DEPTH));
                write_word(written[$], '1, random_word());
            end
        end
        foreach (written[i]) begin
            read_word(written[i]);
        end

        // single byte, random and full strobes over words already written
        for (int n = 0; n < 24; n++) begin
            pick = $unsigned($random(seed)) % written.size();
            if (n % 3 == 0) begin
                sel = BANK_STRB_WIDTH'(1) << (n % BANK_STRB_WIDTH);
            end else if (n % 3 == 1) begin
                sel = BANK_STRB_WIDTH'($random(seed));
            end else begin
                sel = '1;
            end
            write_word(written[pick], sel, random_word());
            read_word(written[pick]);
        end

        // stall windows on reads of tile 0, the farthest one
        for (int n = 0; n < WORDS_PER_TILE; n++) begin
            access_with_stall(1'b0, written[n], '0, '0, n % 7, 1 + n % 4);
        end
        idle_stall(3);
        access_with_stall(1'b1, written[2], 8'h0f, random_word(), 0, 3);
        read_word(written[2]);

        repeat (3) @(negedge clk);
        if (u_global_buffer.u_global_buffer_assertions.fail_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Simulation FAILED");
            $fatal(1, "checks failed during the run");
        end
    end

endmodule

/* src.f */
+incdir+tests
rtl/glb_pkg.sv
rtl/glb_req_if.sv
rtl/glb_bank.sv
rtl/glb_tile.sv
rtl/glb_host_bridge.sv
rtl/global_buffer.sv
tests/global_buffer_assertions.sv
tests/tb_global_buffer.sv
